// ==== src/csr_engine_defines.svh ====
// CSR index engine parameters
`ifndef CSR_ENGINE_DEFINES_SVH
`define CSR_ENGINE_DEFINES_SVH

// ------------------------------
// Datapath widths
// ------------------------------
// Array base address and configuration value
`define CSR_ADDR_W 32
// Vertex index
`define CSR_INDEX_W 16

// ------------------------------
// Buffering and addressing
// ------------------------------
// Entries in each packet FIFO, power of two
`define CSR_FIFO_DEPTH 8
// log2 of bytes per array word
`define CSR_WORD_SHIFT 2

`endif

// ==== src/csr_engine_pkg.sv ====
// CSR index engine types
`default_nettype none

`include "csr_engine_defines.svh"

package csr_engine_pkg;

    // Which configuration register a response word targets
    typedef enum logic [1:0] {
        FIELD_BASE  = 2'd0,
        FIELD_START = 2'd1,
        FIELD_END   = 2'd2
    } cfg_field_e;

    // Tagged configuration word from memory
    typedef struct packed {
        cfg_field_e              field;
        logic [`CSR_ADDR_W-1:0]  value;
    } mem_response_t;

    // One read request towards memory
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`CSR_INDEX_W-1:0] index;
    } mem_request_t;

    // Assembled index range
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]  base_addr;
        logic [`CSR_INDEX_W-1:0] start_index;
        logic [`CSR_INDEX_W-1:0] end_index;
    } index_config_t;

endpackage : csr_engine_pkg

`default_nettype wire

// ==== src/csr_config_if.sv ====
// Index configuration handoff
`timescale 1ns/100ps
`default_nettype none

`include "csr_engine_defines.svh"

interface csr_config_if;

    logic                    valid;
    logic                    ready;
    logic [`CSR_ADDR_W-1:0]  base_addr;
    logic [`CSR_INDEX_W-1:0] start_index;
    logic [`CSR_INDEX_W-1:0] end_index;

    // Offers a completed configuration
    modport collector (output valid, base_addr, start_index, end_index, input ready);

    // Takes it when idle
    modport generator (input valid, base_addr, start_index, end_index, output ready);

endinterface : csr_config_if

`default_nettype wire

// ==== src/packet_fifo.sv ====
// Show-ahead packet FIFO
`timescale 1ns/100ps
`default_nettype none

`include "csr_engine_defines.svh"

module packet_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `CSR_FIFO_DEPTH
) (
    input  wire logic ap_clk,
    input  wire logic areset_csr_engine,
    input  wire logic push_i,
    input  payload_t  data_i,
    output logic      full_o,
    input  wire logic pop_i,
    output payload_t  data_o,
    output logic      empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // Head entry is always on the output
    assign data_o  = mem[rd_ptr_q];
    assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
    assign empty_o = (count_q == '0);

    a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(push_i && full_o));
    a_no_pop_empty: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(pop_i && empty_o));

endmodule : packet_fifo

`default_nettype wire

// ==== src/config_collector.sv ====
// Index configuration collector
`timescale 1ns/100ps
`default_nettype none

`include "csr_engine_defines.svh"

module config_collector (
    input  wire logic                  ap_clk,
    input  wire logic                  areset_csr_engine,
    input  wire logic                  rsp_empty_i,
    output logic                       rsp_pop_o,
    input  csr_engine_pkg::mem_response_t rsp_data_i,
    csr_config_if.collector            cfg,
    output logic                       idle_o
);

    import csr_engine_pkg::*;

    index_config_t cfg_q;
    logic [2:0]    have_q;
    logic          cfg_full;
    logic          cfg_taken;

    // Hold off the FIFO while a complete set waits for the generator
    assign cfg_full  = &have_q;
    assign rsp_pop_o = !rsp_empty_i && !cfg_full;
    assign cfg_taken = cfg.valid && cfg.ready;

    // ------------------------------
    // Field presence
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            have_q <= '0;
        end else if (cfg_taken) begin
            have_q <= '0;
        end else if (rsp_pop_o) begin
            case (rsp_data_i.field)
                FIELD_BASE:  have_q[0] <= 1'b1;
                FIELD_START: have_q[1] <= 1'b1;
                FIELD_END:   have_q[2] <= 1'b1;
                default:     have_q    <= have_q;
            endcase
        end
    end

    // Field values, a repeated tag overwrites
    always_ff @(posedge ap_clk) begin
        if (rsp_pop_o) begin
            case (rsp_data_i.field)
                FIELD_BASE:  cfg_q.base_addr   <= rsp_data_i.value;
                FIELD_START: cfg_q.start_index <= rsp_data_i.value[`CSR_INDEX_W-1:0];
                FIELD_END:   cfg_q.end_index   <= rsp_data_i.value[`CSR_INDEX_W-1:0];
                default:     cfg_q             <= cfg_q;
            endcase
        end
    end

    assign cfg.valid       = cfg_full;
    assign cfg.base_addr   = cfg_q.base_addr;
    assign cfg.start_index = cfg_q.start_index;
    assign cfg.end_index   = cfg_q.end_index;
    assign idle_o          = (have_q == '0);

    a_offer_held: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        cfg.valid && !cfg.ready |=> cfg.valid && $stable(cfg.base_addr)
            && $stable(cfg.start_index) && $stable(cfg.end_index));

endmodule : config_collector

`default_nettype wire

// ==== src/index_request_generator.sv ====
// Vertex index request generator
`timescale 1ns/100ps
`default_nettype none

`include "csr_engine_defines.svh"

module index_request_generator (
    input  wire logic                 ap_clk,
    input  wire logic                 areset_csr_engine,
    csr_config_if.generator           cfg,
    input  wire logic                 req_full_i,
    output logic                      req_push_o,
    output csr_engine_pkg::mem_request_t req_data_o,
    output logic                      idle_o
);

    localparam logic [`CSR_ADDR_W-1:0] ADDR_STEP = `CSR_ADDR_W'(1) << `CSR_WORD_SHIFT;

    logic                    busy_q;
    logic [`CSR_INDEX_W-1:0] end_q;
    logic [`CSR_INDEX_W-1:0] index_q;
    logic [`CSR_INDEX_W-1:0] index_next;
    logic [`CSR_ADDR_W-1:0]  addr_q;
    logic                    cfg_taken;

    assign cfg.ready  = !busy_q;
    assign cfg_taken  = cfg.valid && cfg.ready;
    assign index_next = index_q + 1'b1;

    // One request per cycle with room downstream
    assign req_push_o       = busy_q && !req_full_i;
    assign req_data_o.addr  = addr_q;
    assign req_data_o.index = index_q;
    assign idle_o           = !busy_q;

    // ------------------------------
    // Run control
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            busy_q <= 1'b0;
        end else if (cfg_taken) begin
            // Empty or inverted range is consumed without output
            busy_q <= (cfg.start_index < cfg.end_index);
        end else if (req_push_o && (index_next == end_q)) begin
            busy_q <= 1'b0;
        end
    end

    // ------------------------------
    // Running index and address
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_taken) begin
            end_q   <= cfg.end_index;
            index_q <= cfg.start_index;
            addr_q  <= cfg.base_addr
                + (`CSR_ADDR_W'(cfg.start_index) << `CSR_WORD_SHIFT);
        end else if (req_push_o) begin
            index_q <= index_next;
            addr_q  <= addr_q + ADDR_STEP;
        end
    end

    a_index_in_range: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        req_push_o |-> (req_data_o.index < end_q));

endmodule : index_request_generator

`default_nettype wire

// ==== src/csr_index_engine.sv ====
// CSR index engine top level
`timescale 1ns/100ps
`default_nettype none

`include "csr_engine_defines.svh"

module csr_index_engine (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_csr_engine,
    input  wire logic                    rsp_req_i,
    input  csr_engine_pkg::cfg_field_e   rsp_field_i,
    input  wire logic [`CSR_ADDR_W-1:0]  rsp_value_i,
    output logic                         rsp_ack_o,
    output logic                         mem_req_o,
    output logic [`CSR_ADDR_W-1:0]       mem_addr_o,
    output logic [`CSR_INDEX_W-1:0]      mem_index_o,
    input  wire logic                    mem_ack_i,
    output logic                         done_o
);

    import csr_engine_pkg::*;

    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_WAIT_LOW
    } out_state_e;

    mem_response_t rsp_din;
    mem_response_t rsp_dout;
    logic          rsp_push;
    logic          rsp_full;
    logic          rsp_pop;
    logic          rsp_empty;

    mem_request_t  req_din;
    mem_request_t  req_dout;
    mem_request_t  req_hold_q;
    logic          req_push;
    logic          req_full;
    logic          req_pop;
    logic          req_empty;

    out_state_e    out_state_q;
    logic          coll_idle;
    logic          gen_idle;

    csr_config_if cfg_if ();

    // ------------------------------
    // Response port, four-phase
    // ------------------------------
    assign rsp_din  = '{field: rsp_field_i, value: rsp_value_i};
    assign rsp_push = rsp_req_i && !rsp_ack_o && !rsp_full;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            rsp_ack_o <= 1'b0;
        end else if (rsp_push) begin
            rsp_ack_o <= 1'b1;
        end else if (!rsp_req_i) begin
            rsp_ack_o <= 1'b0;
        end
    end

    packet_fifo #(.payload_t(mem_response_t), .DEPTH(`CSR_FIFO_DEPTH)) rsp_fifo_i (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .push_i(rsp_push), .data_i(rsp_din), .full_o(rsp_full),
        .pop_i(rsp_pop), .data_o(rsp_dout), .empty_o(rsp_empty)
    );

    config_collector config_collector_i (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .rsp_empty_i(rsp_empty), .rsp_pop_o(rsp_pop), .rsp_data_i(rsp_dout),
        .cfg(cfg_if.collector), .idle_o(coll_idle)
    );

    index_request_generator index_request_generator_i (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .cfg(cfg_if.generator), .req_full_i(req_full),
        .req_push_o(req_push), .req_data_o(req_din), .idle_o(gen_idle)
    );

    packet_fifo #(.payload_t(mem_request_t), .DEPTH(`CSR_FIFO_DEPTH)) req_fifo_i (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .push_i(req_push), .data_i(req_din), .full_o(req_full),
        .pop_i(req_pop), .data_o(req_dout), .empty_o(req_empty)
    );

    // ------------------------------
    // Request port, four-phase
    // ------------------------------
    // Next pop waits until the previous ack has been seen low
    assign req_pop = !req_empty
        && ((out_state_q == OUT_IDLE) || ((out_state_q == OUT_WAIT_LOW) && !mem_ack_i));

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            out_state_q <= OUT_IDLE;
        end else begin
            case (out_state_q)
                OUT_IDLE:     if (req_pop) out_state_q <= OUT_REQ;
                OUT_REQ:      if (mem_ack_i) out_state_q <= OUT_WAIT_LOW;
                OUT_WAIT_LOW: if (!mem_ack_i) out_state_q <= req_pop ? OUT_REQ : OUT_IDLE;
                default:      out_state_q <= OUT_IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (req_pop) begin
            req_hold_q <= req_dout;
        end
    end

    assign mem_req_o   = (out_state_q == OUT_REQ);
    assign mem_addr_o  = req_hold_q.addr;
    assign mem_index_o = req_hold_q.index;

    // Nothing held anywhere, last request fully acknowledged
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            done_o <= 1'b1;
        end else begin
            done_o <= coll_idle && gen_idle && rsp_empty && req_empty
                && (out_state_q == OUT_IDLE);
        end
    end

endmodule : csr_index_engine

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 3
) (
    output logic ap_clk,
    output logic areset_csr_engine
);

    initial begin
        ap_clk = 1'b0;
        forever #(HALF_PERIOD_NS) ap_clk = ~ap_clk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        areset_csr_engine = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== test/tb_csr_index_engine.sv ====
// CSR index engine testbench
`timescale 1ns/100ps
`default_nettype none

`include "csr_engine_defines.svh"

module tb_csr_index_engine;

    import csr_engine_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int NUM_ROWS       = 8;

    typedef struct packed {
        logic [31:0] base;
        logic [15:0] start_idx;
        logic [15:0] end_idx;
        logic [2:0]  order;
        logic        dup;
        logic [7:0]  max_delay;
    } run_row_t;

    // ------------------------------
    // Stimulus table
    // ------------------------------
    // base, start, end, field order, duplicate, max ack delay
    run_row_t run_table [NUM_ROWS] = '{
        '{32'h1000_0000, 16'd0,     16'd5,     3'd0, 1'b0, 8'd0},
        '{32'h2000_0040, 16'd3,     16'd12,    3'd3, 1'b1, 8'd3},
        '{32'h0000_8000, 16'd10,    16'd10,    3'd5, 1'b0, 8'd0},
        '{32'h3000_0000, 16'd9,     16'd4,     3'd2, 1'b1, 8'd1},
        '{32'h4000_0100, 16'd100,   16'd120,   3'd1, 1'b0, 8'd12},
        '{32'hffff_fff0, 16'd0,     16'd6,     3'd4, 1'b1, 8'd9},
        '{32'h5000_0000, 16'd65530, 16'd65535, 3'd0, 1'b0, 8'd2},
        '{32'h6000_0000, 16'd1,     16'd2,     3'd3, 1'b0, 8'd0}
    };

    logic                    ap_clk;
    logic                    areset_csr_engine;
    logic                    rsp_req_i;
    cfg_field_e              rsp_field_i;
    logic [`CSR_ADDR_W-1:0]  rsp_value_i;
    logic                    rsp_ack_o;
    logic                    mem_req_o;
    logic [`CSR_ADDR_W-1:0]  mem_addr_o;
    logic [`CSR_INDEX_W-1:0] mem_index_o;
    logic                    mem_ack_i;
    logic                    done_o;

    logic [31:0] exp_addr_q [$];
    logic [15:0] exp_index_q [$];
    integer      seed = 42383;
    int          cur_max_delay = 0;
    int          done_low_cycles = 0;

    tb_clock_gen clock_gen_i (.ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine));

    csr_index_engine csr_index_engine_i (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .rsp_req_i(rsp_req_i), .rsp_field_i(rsp_field_i), .rsp_value_i(rsp_value_i),
        .rsp_ack_o(rsp_ack_o), .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
        .mem_index_o(mem_index_o), .mem_ack_i(mem_ack_i), .done_o(done_o)
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Six orders of the three field tags
    function automatic cfg_field_e field_at(input logic [2:0] order, input int pos);
        cfg_field_e seq [3];
        case (order)
            3'd0:    seq = '{FIELD_BASE, FIELD_START, FIELD_END};
            3'd1:    seq = '{FIELD_BASE, FIELD_END, FIELD_START};
            3'd2:    seq = '{FIELD_START, FIELD_BASE, FIELD_END};
            3'd3:    seq = '{FIELD_START, FIELD_END, FIELD_BASE};
            3'd4:    seq = '{FIELD_END, FIELD_BASE, FIELD_START};
            default: seq = '{FIELD_END, FIELD_START, FIELD_BASE};
        endcase
        return seq[pos];
    endfunction

    function automatic logic [31:0] field_value(input run_row_t row, input cfg_field_e f);
        case (f)
            FIELD_BASE:  return row.base;
            FIELD_START: return {16'h0000, row.start_idx};
            default:     return {16'h0000, row.end_idx};
        endcase
    endfunction

    // One request per index, address is base plus index times word size
    task automatic queue_expected(input run_row_t row);
        logic [15:0] idx;
        idx = row.start_idx;
        while (idx < row.end_idx) begin
            exp_addr_q.push_back(row.base + 32'(idx) * 32'd4);
            exp_index_q.push_back(idx);
            idx = idx + 16'd1;
        end
    endtask

    task automatic send_word(input cfg_field_e f, input logic [31:0] v);
        int waited;
        @(posedge ap_clk);
        rsp_field_i <= f;
        rsp_value_i <= v;
        rsp_req_i   <= 1'b1;
        waited = 0;
        do begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_run("timeout waiting for rsp_ack_o to rise");
        end while (rsp_ack_o !== 1'b1);
        @(posedge ap_clk);
        rsp_req_i <= 1'b0;
        waited = 0;
        do begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_run("timeout waiting for rsp_ack_o to fall");
        end while (rsp_ack_o !== 1'b0);
    endtask

    task automatic check_request();
        logic [31:0] exp_addr;
        logic [15:0] exp_index;
        assert (exp_index_q.size() > 0)
            else stop_run("memory request seen while none was expected");
        exp_addr  = exp_addr_q.pop_front();
        exp_index = exp_index_q.pop_front();
        assert (mem_index_o === exp_index)
            else stop_run($sformatf("[FAIL] mem_index_o: got 0x%04h, expected 0x%04h",
                mem_index_o, exp_index));
        assert (mem_addr_o === exp_addr)
            else stop_run($sformatf("[FAIL] mem_addr_o: got 0x%08h, expected 0x%08h",
                mem_addr_o, exp_addr));
    endtask

    // ------------------------------
    // Memory side responder
    // ------------------------------
    initial begin : mem_responder
        int          waited;
        int unsigned draw;
        int          delay;
        mem_ack_i = 1'b0;
        forever begin
            waited = 0;
            do begin
                @(negedge ap_clk);
                waited++;
                if (waited > TIMEOUT_CYCLES) stop_run("no memory request seen in time");
            end while (mem_req_o !== 1'b1);
            check_request();
            draw  = $random(seed);
            delay = draw % (cur_max_delay + 1);
            repeat (delay) @(posedge ap_clk);
            @(posedge ap_clk);
            mem_ack_i <= 1'b1;
            waited = 0;
            do begin
                @(negedge ap_clk);
                waited++;
                if (waited > TIMEOUT_CYCLES) stop_run("mem_req_o stayed high after ack");
            end while (mem_req_o !== 1'b0);
            @(posedge ap_clk);
            mem_ack_i <= 1'b0;
        end
    end

    always @(negedge ap_clk) begin
        if (done_o === 1'b0) done_low_cycles <= done_low_cycles + 1;
    end

    initial begin : stimulus
        run_row_t row;
        int       waited;
        int       low_mark;
        bit       chained;
        rsp_req_i   = 1'b0;
        rsp_field_i = FIELD_BASE;
        rsp_value_i = '0;
        waited = 0;
        do begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_run("reset was never released");
        end while (areset_csr_engine !== 1'b0);
        assert (rsp_ack_o === 1'b0)
            else stop_run($sformatf("[FAIL] rsp_ack_o: got 0x%0h, expected 0x0", rsp_ack_o));
        assert (mem_req_o === 1'b0)
            else stop_run($sformatf("[FAIL] mem_req_o: got 0x%0h, expected 0x0", mem_req_o));
        assert (done_o === 1'b1)
            else stop_run($sformatf("[FAIL] done_o: got 0x%0h, expected 0x1", done_o));

        for (int r = 0; r < NUM_ROWS; r++) begin
            row           = run_table[r];
            cur_max_delay = row.max_delay;
            low_mark      = done_low_cycles;
            queue_expected(row);
            // Stale copy first, the real value must win
            if (row.dup) begin
                send_word(field_at(row.order, 0), ~field_value(row, field_at(row.order, 0)));
            end
            for (int p = 0; p < 3; p++) begin
                send_word(field_at(row.order, p), field_value(row, field_at(row.order, p)));
            end
            // Done is still low when the previous run was left draining
            if (!chained && (row.start_idx < row.end_idx)) begin
                assert (done_low_cycles != low_mark)
                    else stop_run("done_o did not go low during a non-empty run");
            end
            // Slow-ack rows run straight into the next one
            chained = (row.max_delay >= 8) && (r < NUM_ROWS - 1);
            if (!chained) begin
                waited = 0;
                do begin
                    @(negedge ap_clk);
                    waited++;
                    if (waited > TIMEOUT_CYCLES) stop_run("timeout waiting for done_o");
                end while (done_o !== 1'b1);
                assert (exp_index_q.size() == 0)
                    else stop_run($sformatf("run ended with %0d requests missing",
                        exp_index_q.size()));
                assert ((mem_req_o === 1'b0) && (mem_ack_i === 1'b0))
                    else stop_run("done_o rose before the last memory handshake closed");
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_csr_index_engine

`default_nettype wire

// ==== src.f ====
+incdir+src
src/csr_engine_pkg.sv
src/csr_config_if.sv
src/packet_fifo.sv
src/config_collector.sv
src/index_request_generator.sv
src/csr_index_engine.sv
test/tb_clock_gen.sv
test/tb_csr_index_engine.sv

// ==== Makefile ====
# Verilator simulation of the CSR index engine

VERILATOR ?= verilator
TOP       ?= tb_csr_index_engine
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and scan $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF -- '$(PASS_MSG)' $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
